/* common/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // --------------------------------------------------
    // AXI channel field types
    // --------------------------------------------------

    // Byte address as seen on AR and AW.
    typedef logic [15:0] axi_addr_t;

    // Burst length minus one.
    typedef logic [7:0] axi_len_t;

    typedef logic [31:0] axi_data_t; // One beat.
    typedef logic [3:0]  axi_strb_t; // One bit per byte lane.

    // --------------------------------------------------
    // Response codes
    // --------------------------------------------------

    typedef logic [1:0] axi_resp_t;

    // Only OKAY is ever returned.
    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // --------------------------------------------------
    // Word memory types
    // --------------------------------------------------

    // Stored word, same width as an AXI beat.
    typedef logic [31:0] mem_word_t;

    // Byte enables for a word write.
    typedef logic [3:0] mem_strb_t;

    // Word index.
    // Wide enough for the largest memory, a smaller memory
    // looks only at the low bits.
    typedef logic [13:0] mem_addr_t;

endpackage

`default_nettype wire

/* source/credit_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module credit_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             AR_VALID,

    // Write side, sender tracks space by credits.
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_credit,

    // Show-ahead read side.
    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    input  logic             i_pop
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop_ok;

    // --------------------------------------------------
    // Head and credit return
    // --------------------------------------------------

    assign o_valid  = (count != '0);
    assign o_data   = mem[rd_ptr];
    assign pop_ok   = i_pop && o_valid;
    assign o_credit = pop_ok; // One credit per removed entry.

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------

    always_ff @(posedge clk, posedge AR_VALID) begin
        if (AR_VALID) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(i_push) - CW'(pop_ok);
        end
    end

    // Storage.
    always_ff @(posedge clk) begin
        if (i_push) mem[wr_ptr] <= i_data;
    end

endmodule

`default_nettype wire

/* source/mem_array.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_array
    import mem_pkg::*;
#(
    parameter int MEM_WORDS  = 1024,
    parameter int RESP_DEPTH = 4
) (
    input  logic      clk,
    input  logic      AR_VALID,

    // Head of the request buffer.
    input  logic      i_req_valid,
    input  logic      i_req_we,
    input  mem_strb_t i_req_strb,
    input  mem_addr_t i_req_addr,
    input  mem_word_t i_req_data,
    output logic      o_req_pop,

    // Read words into the response buffer.
    output logic      o_resp_push,
    output mem_word_t o_resp_data,
    input  logic      i_resp_credit
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(RESP_DEPTH + 1);

    mem_word_t mem [MEM_WORDS];

    logic [AW-1:0] idx;
    logic [CW-1:0] credit_q;
    logic [CW-1:0] credit_free;
    logic          rd_pop;
    logic          push_q;
    mem_word_t     rd_q;

    // Low index bits only, so addresses wrap at the memory size.
    assign idx = i_req_addr[AW-1:0];

    // A read popped last cycle still owes its push.
    assign credit_free = credit_q - CW'(push_q);

    // --------------------------------------------------
    // Request acceptance
    // --------------------------------------------------

    assign o_req_pop = i_req_valid && (i_req_we || (credit_free != '0));
    assign rd_pop    = o_req_pop && !i_req_we;

    assign o_resp_push = push_q;
    assign o_resp_data = rd_q;

    always_ff @(posedge clk, posedge AR_VALID) begin
        if (AR_VALID) begin
            push_q   <= 1'b0;
            credit_q <= CW'(RESP_DEPTH);
        end else begin
            push_q   <= rd_pop;
            credit_q <= credit_q + CW'(i_resp_credit) - CW'(o_resp_push);
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (o_req_pop && i_req_we) begin
            for (int b = 0; b < $bits(mem_strb_t); b++) begin
                if (i_req_strb[b]) begin
                    mem[idx][8*b +: 8] <= i_req_data[8*b +: 8];
                end
            end
        end
        if (rd_pop) rd_q <= mem[idx]; // Word for next cycle's push.
    end

endmodule

`default_nettype wire

/* axi_slave/axi_slave.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_slave
    import axi_pkg::*, mem_pkg::*;
#(
    parameter int REQ_DEPTH = 4
) (
    input  logic      clk,
    input  logic      AR_VALID,

    // Read address.
    input  logic      i_ar_valid,
    output logic      o_ar_ready,
    input  axi_addr_t i_ar_addr,
    input  axi_len_t  i_ar_len,

    // Read data.
    output logic      o_r_valid,
    input  logic      i_r_ready,
    output axi_data_t o_r_data,
    output axi_resp_t o_r_resp,
    output logic      o_r_last,

    // Write address.
    input  logic      i_aw_valid,
    output logic      o_aw_ready,
    input  axi_addr_t i_aw_addr,
    input  axi_len_t  i_aw_len,

    // Write data.
    input  logic      i_w_valid,
    output logic      o_w_ready,
    input  axi_data_t i_w_data,
    input  axi_strb_t i_w_strb,
    input  logic      i_w_last,

    // Write response.
    output logic      o_b_valid,
    input  logic      i_b_ready,
    output axi_resp_t o_b_resp,

    // Word requests towards the memory.
    output logic      o_req_push,
    output logic      o_req_we,
    output mem_strb_t o_req_strb,
    output mem_addr_t o_req_addr,
    output mem_word_t o_req_data,
    input  logic      i_req_credit,

    // Read words coming back.
    input  logic      i_resp_valid,
    input  mem_word_t i_resp_data,
    output logic      o_resp_pop
);

    localparam int CW = $clog2(REQ_DEPTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        RESP
    } state_t;

    state_t    state_q;
    state_t    state_d;

    axi_len_t  len_q;     // Length of the burst in progress.
    mem_addr_t addr_q;    // Word index of the next request.
    logic [8:0] iss_cnt;  // Requests issued so far.
    axi_len_t  r_cnt;     // R beats transferred so far.
    logic [CW-1:0] credit_q;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;
    logic rd_issue;
    logic w_final;

    // --------------------------------------------------
    // Channel handshakes
    // --------------------------------------------------

    // AW is held off while AR waits, so reads win a tie.
    assign o_ar_ready = (state_q == IDLE);
    assign o_aw_ready = (state_q == IDLE) && !i_ar_valid;
    assign o_w_ready  = (state_q == WRITE) && (credit_q != '0);

    assign ar_hs = i_ar_valid && o_ar_ready;
    assign aw_hs = i_aw_valid && o_aw_ready;
    assign w_hs  = i_w_valid && o_w_ready;
    assign r_hs  = o_r_valid && i_r_ready;
    assign b_hs  = o_b_valid && i_b_ready;

    // Beat count ends a write burst, i_w_last is not consulted.
    assign w_final = (iss_cnt[7:0] == len_q);

    // --------------------------------------------------
    // Request issue
    // --------------------------------------------------

    assign rd_issue = (state_q == READ) && (credit_q != '0) &&
                      (iss_cnt != ({1'b0, len_q} + 9'd1));

    assign o_req_push = rd_issue || w_hs;
    assign o_req_we   = (state_q == WRITE);
    assign o_req_strb = i_w_strb;
    assign o_req_addr = addr_q;
    assign o_req_data = i_w_data;

    // --------------------------------------------------
    // Response side
    // --------------------------------------------------

    assign o_r_valid  = (state_q == READ) && i_resp_valid;
    assign o_r_data   = i_resp_data;
    assign o_r_resp   = RESP_OKAY;
    assign o_r_last   = o_r_valid && (r_cnt == len_q);
    assign o_resp_pop = r_hs;

    assign o_b_valid = (state_q == RESP);
    assign o_b_resp  = RESP_OKAY;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ar_hs) begin
                    state_d = READ;
                end else if (aw_hs) begin
                    state_d = WRITE;
                end
            end
            READ: begin
                if (r_hs && o_r_last) state_d = IDLE;
            end
            WRITE: begin
                if (w_hs && w_final) state_d = RESP;
            end
            RESP: begin
                if (b_hs) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge AR_VALID) begin
        if (AR_VALID) begin
            state_q  <= IDLE;
            len_q    <= '0;
            addr_q   <= '0;
            iss_cnt  <= '0;
            r_cnt    <= '0;
            credit_q <= CW'(REQ_DEPTH); // Buffer starts empty.
        end else begin
            state_q  <= state_d;
            credit_q <= credit_q + CW'(i_req_credit) - CW'(o_req_push);

            if (ar_hs) begin
                len_q   <= i_ar_len;
                addr_q  <= i_ar_addr[15:2]; // Byte to word.
                iss_cnt <= '0;
                r_cnt   <= '0;
            end else if (aw_hs) begin
                len_q   <= i_aw_len;
                addr_q  <= i_aw_addr[15:2];
                iss_cnt <= '0;
            end else if (o_req_push) begin
                addr_q  <= addr_q + 1'b1;
                iss_cnt <= iss_cnt + 9'd1;
            end

            if (r_hs) r_cnt <= r_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/axi_mem_top.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_mem_top
    import axi_pkg::*, mem_pkg::*;
#(
    parameter int REQ_DEPTH  = 4,
    parameter int RESP_DEPTH = 4,
    parameter int MEM_WORDS  = 1024
) (
    input  logic      clk,
    input  logic      AR_VALID,
    input  logic      i_ar_valid,
    output logic      o_ar_ready,
    input  axi_addr_t i_ar_addr,
    input  axi_len_t  i_ar_len,
    output logic      o_r_valid,
    input  logic      i_r_ready,
    output axi_data_t o_r_data,
    output axi_resp_t o_r_resp,
    output logic      o_r_last,
    input  logic      i_aw_valid,
    output logic      o_aw_ready,
    input  axi_addr_t i_aw_addr,
    input  axi_len_t  i_aw_len,
    input  logic      i_w_valid,
    output logic      o_w_ready,
    input  axi_data_t i_w_data,
    input  axi_strb_t i_w_strb,
    input  logic      i_w_last,
    output logic      o_b_valid,
    input  logic      i_b_ready,
    output axi_resp_t o_b_resp
);

    // Request entry is {we, strb, addr, data}.
    localparam int REQ_W = 1 + $bits(mem_strb_t) + $bits(mem_addr_t) + $bits(mem_word_t);

    logic      req_push,  req_we,  req_credit;
    mem_strb_t req_strb;
    mem_addr_t req_addr;
    mem_word_t req_data;

    logic             head_valid, head_pop;
    logic [REQ_W-1:0] head_entry;
    logic             head_we;
    mem_strb_t        head_strb;
    mem_addr_t        head_addr;
    mem_word_t        head_data;

    logic      resp_push, resp_credit, resp_valid, resp_pop;
    mem_word_t resp_wdata, resp_rdata;

    assign {head_we, head_strb, head_addr, head_data} = head_entry;

    axi_slave #(.REQ_DEPTH(REQ_DEPTH)) axi_slave_i (
        .clk, .AR_VALID,
        .i_ar_valid, .o_ar_ready, .i_ar_addr, .i_ar_len,
        .o_r_valid, .i_r_ready, .o_r_data, .o_r_resp, .o_r_last,
        .i_aw_valid, .o_aw_ready, .i_aw_addr, .i_aw_len,
        .i_w_valid, .o_w_ready, .i_w_data, .i_w_strb, .i_w_last,
        .o_b_valid, .i_b_ready, .o_b_resp,
        .o_req_push(req_push), .o_req_we(req_we), .o_req_strb(req_strb),
        .o_req_addr(req_addr), .o_req_data(req_data), .i_req_credit(req_credit),
        .i_resp_valid(resp_valid), .i_resp_data(resp_rdata), .o_resp_pop(resp_pop)
    );

    credit_fifo #(.WIDTH(REQ_W), .DEPTH(REQ_DEPTH)) req_buf (
        .clk, .AR_VALID,
        .i_push(req_push), .i_data({req_we, req_strb, req_addr, req_data}),
        .o_credit(req_credit), .o_valid(head_valid), .o_data(head_entry),
        .i_pop(head_pop)
    );

    mem_array #(.MEM_WORDS(MEM_WORDS), .RESP_DEPTH(RESP_DEPTH)) mem_array_i (
        .clk, .AR_VALID,
        .i_req_valid(head_valid), .i_req_we(head_we), .i_req_strb(head_strb),
        .i_req_addr(head_addr), .i_req_data(head_data), .o_req_pop(head_pop),
        .o_resp_push(resp_push), .o_resp_data(resp_wdata), .i_resp_credit(resp_credit)
    );

    credit_fifo #(.WIDTH($bits(mem_word_t)), .DEPTH(RESP_DEPTH)) resp_buf (
        .clk, .AR_VALID,
        .i_push(resp_push), .i_data(resp_wdata), .o_credit(resp_credit),
        .o_valid(resp_valid), .o_data(resp_rdata), .i_pop(resp_pop)
    );

endmodule

`default_nettype wire

/* verif/axi_mem_assertions.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_mem_assertions #(
    parameter int REQ_DEPTH  = 4,
    parameter int RESP_DEPTH = 4
) (
    input logic clk,
    input logic AR_VALID,
    input logic i_r_valid,
    input logic i_r_ready,
    input logic i_r_last,
    input logic i_b_valid,
    input logic i_b_ready,
    input logic i_req_push,
    input logic i_req_credit,
    input logic i_resp_push,
    input logic i_resp_credit
);

    int req_cnt;      // Credits held by the slave.
    int resp_cnt;     // Credits held by the memory.
    int fail_cnt = 0;

    always_ff @(posedge clk, posedge AR_VALID) begin
        if (AR_VALID) begin
            req_cnt  <= REQ_DEPTH;
            resp_cnt <= RESP_DEPTH;
        end else begin
            req_cnt  <= req_cnt + int'(i_req_credit) - int'(i_req_push);
            resp_cnt <= resp_cnt + int'(i_resp_credit) - int'(i_resp_push);
        end
    end

    // --------------------------------------------------
    // Channel rules
    // --------------------------------------------------

    r_valid_hold: assert property (@(posedge clk) disable iff (AR_VALID)
        i_r_valid && !i_r_ready |=> i_r_valid) else begin
        $error("R valid dropped before its transfer.");
        fail_cnt++;
    end

    b_valid_hold: assert property (@(posedge clk) disable iff (AR_VALID)
        i_b_valid && !i_b_ready |=> i_b_valid) else begin
        $error("B valid dropped before its transfer.");
        fail_cnt++;
    end

    r_last_valid: assert property (@(posedge clk) disable iff (AR_VALID)
        i_r_last |-> i_r_valid) else begin
        $error("R last seen without R valid.");
        fail_cnt++;
    end

    // --------------------------------------------------
    // Credit rules
    // --------------------------------------------------

    req_credit_ok: assert property (@(posedge clk) disable iff (AR_VALID)
        (req_cnt <= REQ_DEPTH) && !(i_req_push && req_cnt == 0)) else begin
        $error("Request credit count out of range.");
        fail_cnt++;
    end

    resp_credit_ok: assert property (@(posedge clk) disable iff (AR_VALID)
        (resp_cnt <= RESP_DEPTH) && !(i_resp_push && resp_cnt == 0)) else begin
        $error("Response credit count out of range.");
        fail_cnt++;
    end

endmodule

bind axi_mem_top axi_mem_assertions #(
    .REQ_DEPTH(REQ_DEPTH),
    .RESP_DEPTH(RESP_DEPTH)
) axi_mem_assertions_i (
    .clk, .AR_VALID,
    .i_r_valid(o_r_valid), .i_r_ready(i_r_ready), .i_r_last(o_r_last),
    .i_b_valid(o_b_valid), .i_b_ready(i_b_ready),
    .i_req_push(req_push), .i_req_credit(req_credit),
    .i_resp_push(resp_push), .i_resp_credit(resp_credit)
);

`default_nettype wire

/* verif/tb_axi_mem.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_axi_mem import axi_pkg::*; ();

    localparam int REQ_DEPTH    = 4;
    localparam int RESP_DEPTH   = 4;
    localparam int MEM_WORDS    = 1024;
    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_BEATS  = 159; // All bursts of all tests.
    localparam int BURSTS       = 13;
    localparam int TIMEOUT      = 2 * TOTAL_BEATS + RESET_CYCLES + 40 * BURSTS;

    logic      clk = 1'b0;
    logic      AR_VALID;
    logic      i_ar_valid, o_ar_ready, i_r_ready, o_r_valid, o_r_last;
    axi_addr_t i_ar_addr, i_aw_addr;
    axi_len_t  i_ar_len, i_aw_len;
    axi_data_t o_r_data, i_w_data;
    axi_resp_t o_r_resp, o_b_resp;
    logic      i_aw_valid, o_aw_ready, i_w_valid, o_w_ready, i_w_last;
    axi_strb_t i_w_strb;
    logic      o_b_valid, i_b_ready;

    axi_data_t shadow [MEM_WORDS]; // Expected memory contents.
    integer    seed = 32'hfbd6;
    int        cycle_cnt = 0;

    axi_mem_top #(
        .REQ_DEPTH(REQ_DEPTH), .RESP_DEPTH(RESP_DEPTH), .MEM_WORDS(MEM_WORDS)
    ) axi_mem_top_i (.*);

    always #20 clk = ~clk;

    // Watchdog and assertion monitor.
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            $display("Timeout: tests did not complete within %0d cycles.", TIMEOUT);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped by watchdog.");
        end else if (axi_mem_top_i.axi_mem_assertions_i.fail_cnt != 0) begin
            $display("A protocol assertion failed near cycle %0d.", cycle_cnt);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped after assertion failure.");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    // --------------------------------------------------
    // Channel helpers entered and left on a falling edge
    // --------------------------------------------------

    task automatic send_ar(input int word, input int len);
        i_ar_valid = 1'b1;
        i_ar_addr  = axi_addr_t'(word * 4);
        i_ar_len   = axi_len_t'(len);
        #1;
        while (!o_ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk); // AR taken on the rising edge.
        i_ar_valid = 1'b0;
    endtask

    task automatic send_aw(input int word, input int len);
        i_aw_valid = 1'b1;
        i_aw_addr  = axi_addr_t'(word * 4);
        i_aw_len   = axi_len_t'(len);
        #1;
        while (!o_aw_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_aw_valid = 1'b0;
    endtask

    task automatic write_beats(input int word, input int len, input bit mixed);
        axi_data_t data;
        axi_strb_t strb;
        for (int i = 0; i <= len; i++) begin
            data = $random(seed);
            strb = mixed ? axi_strb_t'($random(seed)) : 4'hf;
            i_w_valid = 1'b1;
            i_w_data  = data;
            i_w_strb  = strb;
            i_w_last  = (i == len);
            #1;
            while (!o_w_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[(word + i) % MEM_WORDS][8*b +: 8] = data[8*b +: 8];
            end
        end
        i_w_valid = 1'b0;
        i_w_last  = 1'b0;
    endtask

    task automatic take_b(input string name, input int hold);
        i_b_ready = 1'b0;
        #1;
        while (!o_b_valid) begin
            @(negedge clk);
            #1;
        end
        repeat (hold) begin
            @(negedge clk);
            #1;
            check_value({name, " b_valid held"}, 1, o_b_valid);
            check_value({name, " ar_ready in RESP"}, 0, o_ar_ready);
            check_value({name, " aw_ready in RESP"}, 0, o_aw_ready);
        end
        @(negedge clk);
        i_b_ready = 1'b1;
        #1;
        check_value({name, " b_valid"}, 1, o_b_valid);
        check_value({name, " b_resp"}, RESP_OKAY, o_b_resp);
        @(negedge clk);
        i_b_ready = 1'b0;
    endtask

    task automatic read_beats(input string name, input int word, input int len,
                              input bit rnd);
        int beat = 0;
        while (beat <= len) begin
            i_r_ready = rnd ? 1'($random(seed)) : 1'b1;
            #1;
            if (o_r_valid && i_r_ready) begin
                check_value({name, " data"}, shadow[(word + beat) % MEM_WORDS], o_r_data);
                check_value({name, " r_resp"}, RESP_OKAY, o_r_resp);
                check_value({name, " r_last"}, (beat == len), o_r_last);
                beat++;
            end
            @(negedge clk);
        end
        i_r_ready = 1'b0;
        #1;
        check_value({name, " no extra beat"}, 0, o_r_valid);
        @(negedge clk);
    endtask

    task automatic axi_write(input string name, input int word, input int len,
                             input bit mixed);
        send_aw(word, len);
        write_beats(word, len, mixed);
        take_b(name, 0);
    endtask

    task automatic axi_read(input string name, input int word, input int len,
                            input bit rnd);
        send_ar(word, len);
        read_beats(name, word, len, rnd);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic reset_outputs();
        #1;
        check_value("reset r_valid", 0, o_r_valid);
        check_value("reset b_valid", 0, o_b_valid);
        check_value("reset w_ready", 0, o_w_ready);
        check_value("reset ar_ready", 1, o_ar_ready);
        check_value("reset aw_ready", 1, o_aw_ready);
        @(negedge clk);
    endtask

    task automatic hold_and_priority();
        send_aw(400, 3);
        write_beats(400, 3, 1'b0);
        i_ar_valid = 1'b1; // Both wait behind the held response.
        i_ar_addr  = axi_addr_t'(400 * 4);
        i_ar_len   = 8'd3;
        i_aw_valid = 1'b1;
        i_aw_addr  = axi_addr_t'(500 * 4);
        i_aw_len   = 8'd0;
        take_b("priority", 6);
        #1;
        check_value("priority ar_ready", 1, o_ar_ready);
        check_value("priority aw_ready", 0, o_aw_ready);
        @(negedge clk);
        i_ar_valid = 1'b0;
        read_beats("priority", 400, 3, 1'b0);
        // Waiting AW is taken on the edge after the read ends.
        i_aw_valid = 1'b0;
        #1;
        check_value("priority aw after read", 1, o_w_ready);
        write_beats(500, 0, 1'b0);
        take_b("priority", 0);
    endtask

    initial begin
        AR_VALID   = 1'b1;
        i_ar_valid = 1'b0;
        i_ar_addr  = '0;
        i_ar_len   = '0;
        i_r_ready  = 1'b0;
        i_aw_valid = 1'b0;
        i_aw_addr  = '0;
        i_aw_len   = '0;
        i_w_valid  = 1'b0;
        i_w_data   = '0;
        i_w_strb   = '0;
        i_w_last   = 1'b0;
        i_b_ready  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        AR_VALID = 1'b0;
        @(negedge clk);

        reset_outputs();
        axi_write("single", 100, 0, 1'b0);
        axi_read("single", 100, 0, 1'b0);
        axi_write("strobe", 200, 15, 1'b0);
        axi_write("strobe", 200, 15, 1'b1); // Partial lanes over known data.
        axi_read("strobe", 200, 15, 1'b0);
        axi_write("backpressure", 300, 39, 1'b0);
        axi_read("backpressure", 300, 39, 1'b1);
        hold_and_priority();
        axi_write("wrap", MEM_WORDS - 4, 7, 1'b0);
        axi_read("wrap", MEM_WORDS - 4, 7, 1'b0);
        axi_read("wrap low", 0, 3, 1'b0); // Beats past the top land here.

        if (axi_mem_top_i.axi_mem_assertions_i.fail_cnt != 0) begin
            $display("A protocol assertion failed during the run.");
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failures seen.");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
common/axi_pkg.sv
common/mem_pkg.sv
source/credit_fifo.sv
source/mem_array.sv
axi_slave/axi_slave.sv
source/axi_mem_top.sv
verif/axi_mem_assertions.sv
verif/tb_axi_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AXI memory testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_axi_mem \
    -o sim_axi_mem > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_axi_mem +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
